/* Bender.yml */
package:
  name: hsi_classifier

sources:
  - logic/hsi_pkg.sv
  - logic/sq_df_acc.sv
  - logic/hsi_mse.sv
  - logic/hsi_library_mem.sv
  - logic/hsi_pixel_buf.sv
  - logic/hsi_match_ctrl.sv
  - logic/hsi_min_tracker.sv
  - logic/hsi_classifier.sv
  - target: test
    files:
      - test/tb_hsi_classifier.sv

/* logic/hsi_classifier.sv */
`timescale 1ns/1ps

module hsi_classifier #(
  parameter int  HSI_BANDS        = 128,
  parameter int  HSI_LIBRARY_SIZE = 256,
  localparam int WORDS            = HSI_BANDS / 2,
  localparam int PIX_AW           = $clog2(WORDS),
  localparam int LIB_AW           = $clog2(HSI_LIBRARY_SIZE * WORDS),
  localparam int REF_W            = $clog2(HSI_LIBRARY_SIZE)
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               pix_wr_en,
  input  logic [PIX_AW-1:0]                  pix_wr_addr,
  input  logic [hsi_pkg::WORD_WIDTH-1:0]     pix_wr_data,
  input  logic                               lib_wr_en,
  input  logic [LIB_AW-1:0]                  lib_wr_addr,
  input  logic [hsi_pkg::WORD_WIDTH-1:0]     lib_wr_data,
  input  logic                               start,
  output logic                               busy,
  output logic                               mse_valid,   // One per library entry
  output logic [hsi_pkg::DATA_WIDTH_MUL-1:0] mse_value,
  output logic [REF_W-1:0]                   mse_ref,
  output logic                               match_valid,
  output logic [REF_W-1:0]                   match_ref,
  output logic [hsi_pkg::DATA_WIDTH_MUL-1:0] match_mse
);
  import hsi_pkg::*;

  logic [LIB_AW-1:0] rd_addr;
  hsi_word_t         pix_word, lib_word;
  logic              element_valid, element_start, element_last;
  logic [REF_W-1:0]  vctr_ref;

  hsi_pixel_buf #(.HSI_BANDS(HSI_BANDS)) u_pixel_buf (
    .clk(clk), .rst_n(rst_n), .wr_en(pix_wr_en), .wr_addr(pix_wr_addr),
    .wr_data(pix_wr_data),
    .rd_addr(rd_addr[PIX_AW-1:0]),  // Word part repeats for every entry
    .rd_data(pix_word)
  );

  hsi_library_mem #(.HSI_BANDS(HSI_BANDS), .HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)) u_library (
    .clk(clk), .rst_n(rst_n), .wr_en(lib_wr_en), .wr_addr(lib_wr_addr),
    .wr_data(lib_wr_data), .rd_addr(rd_addr), .rd_data(lib_word)
  );

  hsi_match_ctrl #(.HSI_BANDS(HSI_BANDS), .HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)) u_ctrl (
    .clk(clk), .rst_n(rst_n), .start(start), .match_valid(match_valid),
    .busy(busy), .rd_addr(rd_addr), .element_valid(element_valid),
    .element_start(element_start), .element_last(element_last), .vctr_ref(vctr_ref)
  );

  hsi_mse #(.HSI_BANDS(HSI_BANDS), .HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)) u_mse (
    .clk(clk), .rst_n(rst_n), .element_valid(element_valid),
    .element_start(element_start), .element_last(element_last), .vctr_ref(vctr_ref),
    .element_a(pix_word), .element_b(lib_word),
    .mse_value(mse_value), .mse_ref(mse_ref), .mse_valid(mse_valid)
  );

  hsi_min_tracker #(.HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)) u_min (
    .clk(clk), .rst_n(rst_n), .mse_valid(mse_valid), .mse_value(mse_value),
    .mse_ref(mse_ref), .match_valid(match_valid), .match_ref(match_ref),
    .match_mse(match_mse)
  );

endmodule

/* logic/hsi_library_mem.sv */
`timescale 1ns/1ps

module hsi_library_mem #(
  parameter int  HSI_BANDS        = 128,
  parameter int  HSI_LIBRARY_SIZE = 256,
  localparam int WORDS            = HSI_BANDS / 2,
  localparam int DEPTH            = HSI_LIBRARY_SIZE * WORDS,
  localparam int ADDR_W           = $clog2(DEPTH)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wr_en,
  input  logic [ADDR_W-1:0]  wr_addr,  // Entry times words plus word
  input  hsi_pkg::hsi_word_t wr_data,
  input  logic [ADDR_W-1:0]  rd_addr,
  output hsi_pkg::hsi_word_t rd_data   // One cycle after rd_addr
);
  import hsi_pkg::*;

  logic [WORD_WIDTH-1:0] mem [DEPTH];  // All library spectra, flat

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data.raw;
    end
  end

  // Registered read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data.raw <= '0;
    end else begin
      rd_data.raw <= mem[rd_addr];
    end
  end

endmodule

/* logic/hsi_match_ctrl.sv */
`timescale 1ns/1ps

module hsi_match_ctrl #(
  parameter int  HSI_BANDS        = 128,
  parameter int  HSI_LIBRARY_SIZE = 256,
  localparam int WORDS            = HSI_BANDS / 2,
  localparam int WORD_AW          = $clog2(WORDS),
  localparam int REF_W            = $clog2(HSI_LIBRARY_SIZE),
  localparam int ADDR_W           = $clog2(HSI_LIBRARY_SIZE * WORDS)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,          // Ignored while busy
  input  logic              match_valid,    // Search result out, ends the run
  output logic              busy,
  output logic [ADDR_W-1:0] rd_addr,        // Shared by both memories
  output logic              element_valid,  // Framing lines up with read data
  output logic              element_start,
  output logic              element_last,
  output logic [REF_W-1:0]  vctr_ref
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_ISSUE = 2'd1;  // One word per cycle, no gaps
  localparam logic [1:0] ST_DRAIN = 2'd2;  // Wait for the pipeline to empty

  logic [1:0]         state;
  logic [WORD_AW-1:0] word_cnt;
  logic [REF_W-1:0]   entry_cnt;
  logic               issuing;
  logic               word_end, entry_end;

  assign issuing   = (state == ST_ISSUE);
  assign word_end  = (word_cnt == WORD_AW'(WORDS - 1));
  assign entry_end = (entry_cnt == REF_W'(HSI_LIBRARY_SIZE - 1));
  assign busy      = (state != ST_IDLE);
  assign rd_addr   = {entry_cnt, word_cnt};  // Entry times words plus word

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      word_cnt  <= '0;
      entry_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: if (start) begin
          state     <= ST_ISSUE;
          word_cnt  <= '0;
          entry_cnt <= '0;
        end
        ST_ISSUE: begin
          word_cnt <= word_cnt + 1'b1;  // Wraps at the vector end
          if (word_end) begin
            entry_cnt <= entry_cnt + 1'b1;
            if (entry_end) state <= ST_DRAIN;
          end
        end
        ST_DRAIN: if (match_valid) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Delay the framing by the memory read latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      element_valid <= 1'b0;
      element_start <= 1'b0;
      element_last  <= 1'b0;
      vctr_ref      <= '0;
    end else begin
      element_valid <= issuing;
      element_start <= issuing && (word_cnt == '0);
      element_last  <= issuing && word_end;
      vctr_ref      <= entry_cnt;
    end
  end

endmodule

/* logic/hsi_min_tracker.sv */
`timescale 1ns/1ps

module hsi_min_tracker #(
  parameter int  HSI_LIBRARY_SIZE = 256,
  localparam int REF_W            = $clog2(HSI_LIBRARY_SIZE)
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               mse_valid,
  input  logic [hsi_pkg::DATA_WIDTH_MUL-1:0] mse_value,
  input  logic [REF_W-1:0]                   mse_ref,
  output logic                               match_valid,  // One strobe per search
  output logic [REF_W-1:0]                   match_ref,
  output logic [hsi_pkg::DATA_WIDTH_MUL-1:0] match_mse
);
  import hsi_pkg::*;

  logic [DATA_WIDTH_MUL-1:0] best_mse, next_mse;
  logic [REF_W-1:0]          best_ref, next_ref;
  logic                      take, last_entry;

  assign take       = (mse_ref == '0) || (mse_value < best_mse);  // Strict, ties keep lower index
  assign next_mse   = take ? mse_value : best_mse;
  assign next_ref   = take ? mse_ref : best_ref;
  assign last_entry = (mse_ref == REF_W'(HSI_LIBRARY_SIZE - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      best_mse    <= '0;
      best_ref    <= '0;
      match_valid <= 1'b0;
      match_ref   <= '0;
      match_mse   <= '0;
    end else begin
      match_valid <= mse_valid && last_entry;
      if (mse_valid) begin
        best_mse <= next_mse;
        best_ref <= next_ref;
        if (last_entry) begin
          match_mse <= next_mse;  // Include the final entry
          match_ref <= next_ref;
        end
      end
    end
  end

endmodule

/* logic/hsi_mse.sv */
`timescale 1ns/1ps

module hsi_mse #(
  parameter int  HSI_BANDS        = 128,
  parameter int  HSI_LIBRARY_SIZE = 256,
  localparam int BANDS_LOG2       = $clog2(HSI_BANDS),
  localparam int REF_W            = $clog2(HSI_LIBRARY_SIZE)
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               element_valid,
  input  logic                               element_start,
  input  logic                               element_last,
  input  logic [REF_W-1:0]                   vctr_ref,
  input  hsi_pkg::hsi_word_t                 element_a,  // Pixel word
  input  hsi_pkg::hsi_word_t                 element_b,  // Library word
  output logic [hsi_pkg::DATA_WIDTH_MUL-1:0] mse_value,
  output logic [REF_W-1:0]                   mse_ref,
  output logic                               mse_valid
);
  import hsi_pkg::*;

  logic                      lo_valid, hi_valid;
  logic [DATA_WIDTH_ACC-1:0] lo_value, hi_value;
  logic                      lo_last, hi_last;
  logic [REF_W-1:0]          lo_ref, hi_ref;
  logic                      sum_en;          // Both lanes hold a finished vector
  logic                      sum_valid;
  logic [DATA_WIDTH_ACC:0]   sum_value;       // Carry bit from the lane add
  logic [REF_W-1:0]          sum_ref;
  logic [DATA_WIDTH_ACC:0]   mean;

  assign sum_en = lo_valid && hi_valid && lo_last && hi_last
                  && (lo_ref == hi_ref);     // Lanes run in lockstep
  assign mean   = sum_value >> BANDS_LOG2;  // Divide by the band count

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
      sum_value <= '0;
      sum_ref   <= '0;
      mse_valid <= 1'b0;
      mse_value <= '0;
      mse_ref   <= '0;
    end else begin
      sum_valid <= sum_en;
      if (sum_en) begin
        sum_value <= {1'b0, lo_value} + {1'b0, hi_value};  // Even plus odd bands
        sum_ref   <= lo_ref;
      end
      mse_valid <= sum_valid;
      if (sum_valid) begin
        mse_value <= mean[DATA_WIDTH_MUL-1:0];  // Mean of squares never exceeds one square
        mse_ref   <= sum_ref;
      end
    end
  end

  sq_df_acc #(
    .HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)
  ) channel_lo (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_in_valid(element_valid),
    .data_in_start(element_start),
    .data_in_last (element_last),
    .data_in_ref  (vctr_ref),
    .data_in_a    (element_a.lanes.lo),  // Even bands
    .data_in_b    (element_b.lanes.lo),
    .acc_valid    (lo_valid),
    .acc_value    (lo_value),
    .acc_last     (lo_last),
    .acc_ref      (lo_ref)
  );

  sq_df_acc #(
    .HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)
  ) channel_hi (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_in_valid(element_valid),
    .data_in_start(element_start),
    .data_in_last (element_last),
    .data_in_ref  (vctr_ref),
    .data_in_a    (element_a.lanes.hi),  // Odd bands
    .data_in_b    (element_b.lanes.hi),
    .acc_valid    (hi_valid),
    .acc_value    (hi_value),
    .acc_last     (hi_last),
    .acc_ref      (hi_ref)
  );

endmodule

/* logic/hsi_pixel_buf.sv */
`timescale 1ns/1ps

module hsi_pixel_buf #(
  parameter int  HSI_BANDS = 128,
  localparam int WORDS     = HSI_BANDS / 2,
  localparam int ADDR_W    = $clog2(WORDS)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wr_en,
  input  logic [ADDR_W-1:0]  wr_addr,  // Word index within the pixel
  input  hsi_pkg::hsi_word_t wr_data,
  input  logic [ADDR_W-1:0]  rd_addr,  // Word part of the library address
  output hsi_pkg::hsi_word_t rd_data
);
  import hsi_pkg::*;

  logic [WORD_WIDTH-1:0] pix [WORDS];  // Pixel under test

  always_ff @(posedge clk) begin
    if (wr_en) begin
      pix[wr_addr] <= wr_data.raw;
    end
  end

  // Same latency as the library memory so words stay paired
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data.raw <= '0;
    end else begin
      rd_data.raw <= pix[rd_addr];
    end
  end

endmodule

/* logic/hsi_pkg.sv */
package hsi_pkg;

  localparam int DATA_WIDTH     = 16;  // One band sample
  localparam int WORD_WIDTH     = 32;  // Storage word, two bands
  localparam int DATA_WIDTH_MUL = 32;  // Squared difference
  localparam int DATA_WIDTH_ACC = 48;  // Lane accumulator, room for many bands

  // Two bands per storage word
  // Memories move the raw word, the MSE unit works on the lanes
  typedef union packed {
    logic [WORD_WIDTH-1:0] raw;  // Whole word as stored
    struct packed {
      logic [DATA_WIDTH-1:0] hi;  // Odd band
      logic [DATA_WIDTH-1:0] lo;  // Even band
    } lanes;
  } hsi_word_t;

endpackage

/* logic/sq_df_acc.sv */
`timescale 1ns/1ps

module sq_df_acc #(
  parameter int  HSI_LIBRARY_SIZE = 256,
  localparam int REF_W            = $clog2(HSI_LIBRARY_SIZE)
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            data_in_valid,
  input  logic                            data_in_start,  // First element of a vector
  input  logic                            data_in_last,   // Final element of a vector
  input  logic [REF_W-1:0]                data_in_ref,
  input  logic [hsi_pkg::DATA_WIDTH-1:0]  data_in_a,
  input  logic [hsi_pkg::DATA_WIDTH-1:0]  data_in_b,
  output logic                            acc_valid,      // Final sum of one vector
  output logic [hsi_pkg::DATA_WIDTH_ACC-1:0] acc_value,
  output logic                            acc_last,
  output logic [REF_W-1:0]                acc_ref
);
  import hsi_pkg::*;

  logic                        d_valid, d_start, d_last;  // Difference stage framing
  logic [REF_W-1:0]            d_ref;
  logic signed [DATA_WIDTH:0]  diff;                      // One extra bit for the sign
  logic                        s_valid, s_start, s_last;  // Square stage framing
  logic [REF_W-1:0]            s_ref;
  logic [DATA_WIDTH_MUL-1:0]   sq;
  logic signed [2*DATA_WIDTH+1:0] prod;                   // Full signed product

  assign prod = diff * diff;  // Always positive, fits DATA_WIDTH_MUL

  // Framing travels alongside the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_valid   <= 1'b0;
      d_start   <= 1'b0;
      d_last    <= 1'b0;
      d_ref     <= '0;
      s_valid   <= 1'b0;
      s_start   <= 1'b0;
      s_last    <= 1'b0;
      s_ref     <= '0;
      acc_valid <= 1'b0;
      acc_last  <= 1'b0;
      acc_ref   <= '0;
      acc_value <= '0;
    end else begin
      d_valid   <= data_in_valid;
      d_start   <= data_in_valid && data_in_start;
      d_last    <= data_in_valid && data_in_last;
      d_ref     <= data_in_ref;
      s_valid   <= d_valid;
      s_start   <= d_start;
      s_last    <= d_last;
      s_ref     <= d_ref;
      acc_valid <= s_valid && s_last;  // Pulse only with the complete sum
      acc_last  <= s_valid && s_last;
      if (s_valid) begin
        acc_ref   <= s_ref;
        acc_value <= s_start ? DATA_WIDTH_ACC'(sq)  // New vector restarts the sum
                             : acc_value + DATA_WIDTH_ACC'(sq);
      end
    end
  end

  // Arithmetic path
  always_ff @(posedge clk) begin
    diff <= $signed({1'b0, data_in_a}) - $signed({1'b0, data_in_b});
    sq   <= prod[DATA_WIDTH_MUL-1:0];
  end

endmodule

/* sim.f */
logic/hsi_pkg.sv
logic/sq_df_acc.sv
logic/hsi_mse.sv
logic/hsi_library_mem.sv
logic/hsi_pixel_buf.sv
logic/hsi_match_ctrl.sv
logic/hsi_min_tracker.sv
logic/hsi_classifier.sv
test/tb_hsi_classifier.sv

/* test/tb_hsi_classifier.sv */
`timescale 1ns/1ps

module tb_hsi_classifier;

  localparam int BANDS      = 8;
  localparam int LIB        = 8;
  localparam int WORDS      = BANDS / 2;
  localparam int BANDS_LOG2 = $clog2(BANDS);
  localparam int REF_W      = $clog2(LIB);
  localparam int PIX_AW     = $clog2(WORDS);
  localparam int LIB_AW     = $clog2(LIB * WORDS);
  localparam int NUM_RUNS   = 7;  // Named tests in the whole run
  localparam int TIMEOUT_CYCLES = NUM_RUNS * (LIB * WORDS + 40);

  logic clk, rst_n, start, busy;
  logic pix_wr_en, lib_wr_en;
  logic [PIX_AW-1:0] pix_wr_addr;
  logic [LIB_AW-1:0] lib_wr_addr;
  logic [31:0] pix_wr_data, lib_wr_data;
  logic mse_valid, match_valid;
  logic [31:0] mse_value, match_mse;
  logic [REF_W-1:0] mse_ref, match_ref;

  logic [31:0] pix_m [WORDS];        // Model copy of the pixel
  logic [31:0] lib_m [LIB * WORDS];  // Model copy of the library
  integer seed;
  int mism_cnt, fail_cnt;
  int mse_cnt, match_cnt;            // Strobes seen in the current search
  string test_name;

  hsi_classifier #(.HSI_BANDS(BANDS), .HSI_LIBRARY_SIZE(LIB)) dut (
    .clk(clk), .rst_n(rst_n),
    .pix_wr_en(pix_wr_en), .pix_wr_addr(pix_wr_addr), .pix_wr_data(pix_wr_data),
    .lib_wr_en(lib_wr_en), .lib_wr_addr(lib_wr_addr), .lib_wr_data(lib_wr_data),
    .start(start), .busy(busy),
    .mse_valid(mse_valid), .mse_value(mse_value), .mse_ref(mse_ref),
    .match_valid(match_valid), .match_ref(match_ref), .match_mse(match_mse)
  );

  always #5 clk = ~clk;

  // Mean of the squared band differences
  function automatic longint unsigned model_mse(input int e);
    longint unsigned sum;
    longint d;
    sum = 0;
    for (int w = 0; w < WORDS; w++) begin
      d = longint'(pix_m[w][15:0]) - longint'(lib_m[e * WORDS + w][15:0]);   // Even band
      sum += longint'(d * d);
      d = longint'(pix_m[w][31:16]) - longint'(lib_m[e * WORDS + w][31:16]); // Odd band
      sum += longint'(d * d);
    end
    return sum >> BANDS_LOG2;
  endfunction

  function automatic int best_entry();
    int idx;
    idx = 0;
    for (int e = 1; e < LIB; e++)
      if (model_mse(e) < model_mse(idx)) idx = e;  // Lowest index wins a tie
    return idx;
  endfunction

  task automatic flag_mismatch(input string what, input longint unsigned exp,
                               input longint unsigned act);
    mism_cnt++;
    $display("mismatch %s %s expected %0d actual %0d", test_name, what, exp, act);
  endtask

  task automatic note_failure(input string what);
    fail_cnt++;
    $display("failure in %s: %s", test_name, what);
  endtask

  task automatic put_pixel(input int w, input logic [31:0] d);
    @(posedge clk);
    pix_wr_en   <= 1'b1;
    pix_wr_addr <= PIX_AW'(w);
    pix_wr_data <= d;
    pix_m[w] = d;  // Model follows every write
  endtask

  task automatic put_library(input int e, input int w, input logic [31:0] d);
    @(posedge clk);
    lib_wr_en   <= 1'b1;
    lib_wr_addr <= LIB_AW'(e * WORDS + w);
    lib_wr_data <= d;
    lib_m[e * WORDS + w] = d;
  endtask

  task automatic release_bus();
    @(posedge clk);
    pix_wr_en <= 1'b0;
    lib_wr_en <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // One search with an optional second start while busy
  task automatic run_search(input bit extra_start);
    mse_cnt   = 0;
    match_cnt = 0;
    pulse_start();
    if (extra_start) begin
      repeat (8) @(posedge clk);
      pulse_start();  // Must be ignored
    end
    do @(posedge clk); while (!match_valid);
    repeat (2) @(posedge clk);
    assert (!busy) else note_failure("busy still high after the search");
    assert (mse_cnt == LIB) else flag_mismatch("mse strobes", LIB, mse_cnt);
    assert (match_cnt == 1) else flag_mismatch("match strobes", 1, match_cnt);
  endtask

  // Per-entry and final results against the model
  always @(posedge clk) begin
    if (rst_n && mse_valid) begin
      assert (mse_ref == REF_W'(mse_cnt)) else flag_mismatch("mse_ref", mse_cnt, mse_ref);
      assert (mse_value == model_mse(mse_cnt))
        else flag_mismatch("mse_value", model_mse(mse_cnt), mse_value);
      mse_cnt++;
    end
    if (rst_n && match_valid) begin
      assert (match_ref == REF_W'(best_entry()))
        else flag_mismatch("match_ref", best_entry(), match_ref);
      assert (match_mse == model_mse(best_entry()))
        else flag_mismatch("match_mse", model_mse(best_entry()), match_mse);
      match_cnt++;
    end
  end

  // Busy framing around each search
  a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (start && !busy) |=> busy) else note_failure("accepted start did not raise busy");
  a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (busy && !match_valid) |=> busy) else note_failure("busy fell before match_valid");
  a_busy_end: assert property (@(posedge clk) disable iff (!rst_n)
    match_valid |=> !busy) else note_failure("busy did not fall after match_valid");
  a_mse_busy: assert property (@(posedge clk) disable iff (!rst_n)
    mse_valid |-> busy) else note_failure("mse strobe outside a search");

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    seed = 32'h1da74827;
    clk = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    pix_wr_en = 1'b0;
    pix_wr_addr = '0;
    pix_wr_data = '0;
    lib_wr_en = 1'b0;
    lib_wr_addr = '0;
    lib_wr_data = '0;
    mism_cnt = 0;
    fail_cnt = 0;
    mse_cnt = 0;
    match_cnt = 0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!busy) else flag_mismatch("busy", 0, busy);
    assert (!mse_valid) else flag_mismatch("mse_valid", 0, mse_valid);
    assert (!match_valid) else flag_mismatch("match_valid", 0, match_valid);

    test_name = "random";
    for (int w = 0; w < WORDS; w++) put_pixel(w, $random(seed));
    for (int e = 0; e < LIB; e++)
      for (int w = 0; w < WORDS; w++) put_library(e, w, $random(seed));
    release_bus();
    run_search(1'b0);

    test_name = "exact_copy";
    for (int w = 0; w < WORDS; w++) put_library(5, w, pix_m[w]);
    release_bus();
    run_search(1'b0);
    assert (match_ref == 3'd5) else flag_mismatch("match_ref", 5, match_ref);

    test_name = "tie";  // Every band off by one in entries 2 and 6
    for (int w = 0; w < WORDS; w++) begin
      put_library(2, w, pix_m[w] ^ 32'h0001_0001);
      put_library(6, w, pix_m[w] ^ 32'h0001_0001);
      put_library(5, w, ~pix_m[w]);
    end
    release_bus();
    run_search(1'b0);
    assert (match_ref == 3'd2) else flag_mismatch("match_ref", 2, match_ref);
    assert (match_mse == 32'd1) else flag_mismatch("match_mse", 1, match_mse);

    test_name = "start_while_busy";
    run_search(1'b1);

    test_name = "full_scale";
    for (int w = 0; w < WORDS; w++) put_pixel(w, 32'h0);
    for (int e = 0; e < LIB; e++)
      for (int w = 0; w < WORDS; w++) put_library(e, w, 32'hFFFF_FFFF);
    release_bus();
    run_search(1'b0);
    assert (match_mse == 32'd4294836225)
      else flag_mismatch("match_mse", 32'd4294836225, match_mse);

    test_name = "pixel_reload";
    for (int w = 0; w < WORDS; w++) put_pixel(w, $random(seed));
    release_bus();
    run_search(1'b0);

    $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt + fail_cnt == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule
